// ==== verilog/fifo_cfg_pkg.sv ====
package fifo_cfg_pkg;

  localparam int DEF_DATA_WIDTH = 8;
  localparam int DEF_FIFO_DEPTH = 16; // must stay a power of two.

  // widest pointer the conversions below handle, wrap bit included.
  localparam int PTR_MAX_W = 16;

  function automatic logic [PTR_MAX_W-1:0] bin2gray(input logic [PTR_MAX_W-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits at and above it.
  function automatic logic [PTR_MAX_W-1:0] gray2bin(input logic [PTR_MAX_W-1:0] gray);
    logic [PTR_MAX_W-1:0] bin;
    bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
    for (int i = PTR_MAX_W-2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== verilog/lane_pkg.sv ====
package lane_pkg;

  localparam int DEF_LANES = 4;
  localparam int LANE_W    = $clog2(DEF_LANES); // two bits for four lanes.

  typedef logic [LANE_W-1:0] lane_t;

endpackage

// ==== verilog/dualport_ram.sv ====
`timescale 1ns/100ps

module dualport_ram
  import fifo_cfg_pkg::*;
#(
  parameter  int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter  int FIFO_DEPTH = DEF_FIFO_DEPTH,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk ,
  input  logic                  wr_en  ,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk ,
  input  logic                  rd_en  ,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // the read port is registered, so data follows rd_en by one rd_clk cycle.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== verilog/async_fifo.sv ====
`timescale 1ns/100ps

module async_fifo
  import fifo_cfg_pkg::*;
#(
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = FIFO_DEPTH-1  ,
  parameter int FIFO_AEMPTY = 1
) (
  input  logic                  wr_clk ,
  input  logic                  rst_n  ,
  input  logic                  wr_en  ,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic                  full   ,
  output logic                  afull  ,
  input  logic                  rd_clk ,
  input  logic                  rd_en  ,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  empty  ,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int PTR_W      = ADDR_WIDTH + 1; // one wrap bit above the address.

  logic                 wr_ok;
  logic [PTR_W-1:0]     wr_bin;
  logic [PTR_W-1:0]     wr_bin_nxt;
  logic [PTR_W-1:0]     wr_gray;
  logic [PTR_W-1:0]     wr_gray_nxt;
  logic [PTR_MAX_W-1:0] wr_gray_wide;
  logic [PTR_W-1:0]     rd_gray_ws1;
  logic [PTR_W-1:0]     rd_gray_ws2;
  logic [PTR_MAX_W-1:0] rd_bin_ws_wide;
  logic [PTR_W-1:0]     wr_used_nxt;

  logic                 rd_ok;
  logic [PTR_W-1:0]     rd_bin;
  logic [PTR_W-1:0]     rd_bin_nxt;
  logic [PTR_W-1:0]     rd_gray;
  logic [PTR_W-1:0]     rd_gray_nxt;
  logic [PTR_MAX_W-1:0] rd_gray_wide;
  logic [PTR_W-1:0]     wr_gray_rs1;
  logic [PTR_W-1:0]     wr_gray_rs2;
  logic [PTR_MAX_W-1:0] wr_bin_rs_wide;
  logic [PTR_W-1:0]     rd_used_nxt;

  assign wr_ok = wr_en && !full;  // writes into a full FIFO are dropped here.
  assign rd_ok = rd_en && !empty;

  dualport_ram #(
    .DATA_WIDTH(DATA_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_dualport_ram (
    .wr_clk (wr_clk),
    .wr_en  (wr_ok),
    .wr_addr(wr_bin[ADDR_WIDTH-1:0]),
    .wr_data(wr_data),
    .rd_clk (rd_clk),
    .rd_en  (rd_ok),
    .rd_addr(rd_bin[ADDR_WIDTH-1:0]),
    .rd_data(rd_data)
  );

  assign wr_bin_nxt     = wr_bin + PTR_W'(wr_ok);
  assign wr_gray_wide   = bin2gray(PTR_MAX_W'(wr_bin_nxt));
  assign wr_gray_nxt    = wr_gray_wide[PTR_W-1:0];
  assign rd_bin_ws_wide = gray2bin(PTR_MAX_W'(rd_gray_ws2));
  assign wr_used_nxt    = wr_bin_nxt - rd_bin_ws_wide[PTR_W-1:0];

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_ws1 <= '0;
      rd_gray_ws2 <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_gray     <= wr_gray_nxt;
      rd_gray_ws1 <= rd_gray;     // read pointer crosses into wr_clk here.
      rd_gray_ws2 <= rd_gray_ws1;
      full        <= (wr_used_nxt == PTR_W'(FIFO_DEPTH));
      afull       <= (wr_used_nxt >= PTR_W'(FIFO_AFULL));
    end
  end

  assign rd_bin_nxt     = rd_bin + PTR_W'(rd_ok);
  assign rd_gray_wide   = bin2gray(PTR_MAX_W'(rd_bin_nxt));
  assign rd_gray_nxt    = rd_gray_wide[PTR_W-1:0];
  assign wr_bin_rs_wide = gray2bin(PTR_MAX_W'(wr_gray_rs2));
  assign rd_used_nxt    = wr_bin_rs_wide[PTR_W-1:0] - rd_bin_nxt;

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      wr_gray_rs1 <= '0;
      wr_gray_rs2 <= '0;
      empty       <= 1'b1;
      aempty      <= 1'b1;
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_gray     <= rd_gray_nxt;
      wr_gray_rs1 <= wr_gray;     // write pointer crosses into rd_clk here.
      wr_gray_rs2 <= wr_gray_rs1;
      empty       <= (rd_used_nxt == '0);
      aempty      <= (rd_used_nxt <= PTR_W'(FIFO_AEMPTY));
    end
  end

endmodule

// ==== verilog/lane_dispatch.sv ====
`timescale 1ns/100ps

module lane_dispatch
  import fifo_cfg_pkg::*;
  import lane_pkg::*;
#(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int LANES      = DEF_LANES
) (
  input  logic                  wr_clk      ,
  input  logic                  rst_n       ,
  input  logic                  wr_en       ,
  input  lane_t                 wr_lane     ,
  input  logic [DATA_WIDTH-1:0] wr_data     ,
  output logic [LANES-1:0]      lane_wr_en  ,
  output logic [DATA_WIDTH-1:0] lane_wr_data
);

  logic  wr_en_q;
  lane_t wr_lane_q;

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= wr_en;
    end
  end

  always_ff @(posedge wr_clk) begin
    wr_lane_q    <= wr_lane;
    lane_wr_data <= wr_data; // one data bus feeds every lane.
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_wr_en[i] = wr_en_q && (wr_lane_q == lane_t'(i));
    end
  end

endmodule

// ==== verilog/lane_merge.sv ====
`timescale 1ns/100ps

module lane_merge
  import fifo_cfg_pkg::*;
  import lane_pkg::*;
#(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int LANES      = DEF_LANES
) (
  input  logic                        rd_clk      ,
  input  logic                        rst_n       ,
  input  logic                        rd_en       ,
  input  logic [LANES-1:0]            empty       ,
  input  logic [LANES*DATA_WIDTH-1:0] lane_rd_data,
  output logic [LANES-1:0]            lane_rd_en  ,
  output logic                        rd_valid    ,
  output lane_t                       rd_lane     ,
  output logic [DATA_WIDTH-1:0]       rd_data
);

  lane_t last_q;      // lane of the most recent grant.
  lane_t cand;
  lane_t grant_lane;
  logic  grant_found;
  logic  grant;

  // search starts one past the last grant and wraps around once.
  always_comb begin
    grant_found = 1'b0;
    grant_lane  = last_q;
    cand        = last_q;
    for (int k = 1; k <= LANES; k++) begin
      cand = lane_t'((int'(last_q) + k) % LANES);
      if (!grant_found && !empty[cand]) begin
        grant_found = 1'b1;
        grant_lane  = cand;
      end
    end
  end

  assign grant = rd_en && grant_found; // a request with every lane empty is dropped.

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_rd_en[i] = grant && (grant_lane == lane_t'(i));
    end
  end

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      last_q   <= lane_t'(LANES-1); // lane 0 wins the first grant.
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= grant;
      if (grant) begin
        last_q <= grant_lane;
      end
    end
  end

  // the RAM of the granted lane holds its word by now.
  assign rd_lane = last_q;
  assign rd_data = lane_rd_data[last_q*DATA_WIDTH +: DATA_WIDTH];

endmodule

// ==== verilog/cdc_lane_bridge.sv ====
`timescale 1ns/100ps

module cdc_lane_bridge
  import fifo_cfg_pkg::*;
  import lane_pkg::*;
#(
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = FIFO_DEPTH-1  ,
  parameter int FIFO_AEMPTY = 1             ,
  parameter int LANES       = DEF_LANES
) (
  input  logic                  wr_clk  ,
  input  logic                  rd_clk  ,
  input  logic                  rst_n   ,
  input  logic                  wr_en   ,
  input  lane_t                 wr_lane ,
  input  logic [DATA_WIDTH-1:0] wr_data ,
  input  logic                  rd_en   ,
  output logic                  rd_valid,
  output lane_t                 rd_lane ,
  output logic [DATA_WIDTH-1:0] rd_data ,
  output logic [LANES-1:0]      full    ,
  output logic [LANES-1:0]      afull   ,
  output logic [LANES-1:0]      empty   ,
  output logic [LANES-1:0]      aempty
);

  logic [LANES-1:0]            lane_wr_en;
  logic [DATA_WIDTH-1:0]       lane_wr_data;
  logic [LANES-1:0]            lane_rd_en;
  logic [LANES*DATA_WIDTH-1:0] lane_rd_data;

  lane_dispatch #(
    .DATA_WIDTH(DATA_WIDTH),
    .LANES     (LANES)
  ) i_lane_dispatch (
    .wr_clk      (wr_clk),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_lane     (wr_lane),
    .wr_data     (wr_data),
    .lane_wr_en  (lane_wr_en),
    .lane_wr_data(lane_wr_data)
  );

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    async_fifo #(
      .DATA_WIDTH (DATA_WIDTH),
      .FIFO_DEPTH (FIFO_DEPTH),
      .FIFO_AFULL (FIFO_AFULL),
      .FIFO_AEMPTY(FIFO_AEMPTY)
    ) i_async_fifo (
      .wr_clk (wr_clk),
      .rst_n  (rst_n),
      .wr_en  (lane_wr_en[g]),
      .wr_data(lane_wr_data),
      .full   (full[g]),
      .afull  (afull[g]),
      .rd_clk (rd_clk),
      .rd_en  (lane_rd_en[g]),
      .rd_data(lane_rd_data[g*DATA_WIDTH +: DATA_WIDTH]),
      .empty  (empty[g]),
      .aempty (aempty[g])
    );
  end

  lane_merge #(
    .DATA_WIDTH(DATA_WIDTH),
    .LANES     (LANES)
  ) i_lane_merge (
    .rd_clk      (rd_clk),
    .rst_n       (rst_n),
    .rd_en       (rd_en),
    .empty       (empty),
    .lane_rd_data(lane_rd_data),
    .lane_rd_en  (lane_rd_en),
    .rd_valid    (rd_valid),
    .rd_lane     (rd_lane),
    .rd_data     (rd_data)
  );

endmodule

// ==== bench/cdc_lane_bridge_properties.sv ====
`timescale 1ns/100ps

module cdc_lane_bridge_properties
  import lane_pkg::*;
#(
  parameter int LANES = DEF_LANES
) (
  input logic             rd_clk    ,
  input logic             rst_n     ,
  input logic [LANES-1:0] lane_rd_en,
  input logic [LANES-1:0] empty     ,
  input logic [LANES-1:0] full      ,
  input logic             rd_valid
);

  int fail_count = 0; // failed assertions so far.

  property p_grant_onehot;
    @(posedge rd_clk) disable iff (!rst_n) $onehot0(lane_rd_en);
  endproperty

  // the merger must never pull from a lane that has nothing in it.
  property p_grant_not_empty;
    @(posedge rd_clk) disable iff (!rst_n) (lane_rd_en & empty) == '0;
  endproperty

  property p_full_empty_exclusive;
    @(posedge rd_clk) disable iff (!rst_n) (full & empty) == '0;
  endproperty

  property p_valid_after_grant;
    @(posedge rd_clk) disable iff (!rst_n) (|lane_rd_en) |=> rd_valid;
  endproperty

  property p_valid_needs_grant;
    @(posedge rd_clk) disable iff (!rst_n) rd_valid |-> $past(|lane_rd_en);
  endproperty

  a_grant_onehot: assert property (p_grant_onehot)
    else begin
      $error("lane_rd_en has more than one lane granted");
      fail_count++;
    end
  a_grant_not_empty: assert property (p_grant_not_empty)
    else begin
      $error("lane_rd_en granted a lane that is empty");
      fail_count++;
    end
  a_full_empty_exclusive: assert property (p_full_empty_exclusive)
    else begin
      $error("a lane shows full and empty at once");
      fail_count++;
    end
  a_valid_after_grant: assert property (p_valid_after_grant)
    else begin
      $error("rd_valid missing one cycle after a grant");
      fail_count++;
    end
  a_valid_needs_grant: assert property (p_valid_needs_grant)
    else begin
      $error("rd_valid raised without a grant in the cycle before");
      fail_count++;
    end

endmodule

bind cdc_lane_bridge cdc_lane_bridge_properties #(
  .LANES(LANES)
) i_cdc_lane_bridge_properties (
  .rd_clk    (rd_clk),
  .rst_n     (rst_n),
  .lane_rd_en(lane_rd_en),
  .empty     (empty),
  .full      (full),
  .rd_valid  (rd_valid)
);

// ==== bench/tb_cdc_lane_bridge.sv ====
`timescale 1ns/100ps

module tb_cdc_lane_bridge
  import fifo_cfg_pkg::*;
  import lane_pkg::*;
();

  localparam int DATA_WIDTH  = DEF_DATA_WIDTH;
  localparam int FIFO_DEPTH  = DEF_FIFO_DEPTH;
  localparam int LANES       = DEF_LANES;
  localparam int RAND_CYCLES = 400;
  localparam int RR_WORDS    = 5;
  localparam int RD_PERIOD   = 13;
  // phase lengths in cycles of the slower clock, with room for draining and settling.
  localparam int TOTAL_CYCLES = 10 + 2*RAND_CYCLES + 3*(FIFO_DEPTH+3) + 2*LANES*RR_WORDS + 200;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES*RD_PERIOD*2 + 2000;

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  rst_n;
  logic                  wr_en;
  lane_t                 wr_lane;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_en;
  logic                  rd_valid;
  lane_t                 rd_lane;
  logic [DATA_WIDTH-1:0] rd_data;
  logic [LANES-1:0]      full;
  logic [LANES-1:0]      afull;
  logic [LANES-1:0]      empty;
  logic [LANES-1:0]      aempty;

  logic [DATA_WIDTH-1:0] model_q [LANES][$]; // expected words per lane.
  logic                  s1_en;
  lane_t                 s1_lane;
  logic [DATA_WIDTH-1:0] s1_data;
  logic [DATA_WIDTH-1:0] exp_data;
  lane_t                 exp_lane;
  lane_t                 last_lane;
  logic                  rr_check;
  logic                  writer_done;
  logic [31:0]           lcg_state;
  logic [31:0]           r;
  int                    errors;
  int                    reads_seen;
  int                    reads_before;

  cdc_lane_bridge i_cdc_lane_bridge (.*);

  always #5 wr_clk = ~wr_clk;
  always #6.5 rd_clk = ~rd_clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int total_queued();
    int n;
    n = 0;
    for (int l = 0; l < LANES; l++) begin
      n += model_q[l].size();
    end
    return n;
  endfunction

  // next lane after the last grant that still holds words.
  function automatic lane_t next_busy_lane(input lane_t from);
    lane_t cand;
    lane_t pick;
    logic  found;
    found = 1'b0;
    pick  = from;
    for (int k = 1; k <= LANES; k++) begin
      cand = lane_t'((int'(from) + k) % LANES);
      if (!found && model_q[cand].size() != 0) begin
        found = 1'b1;
        pick  = cand;
      end
    end
    return pick;
  endfunction

  // a word sampled by the dispatcher reaches its FIFO one edge later, unless full.
  always @(posedge wr_clk) begin
    if (!rst_n) begin
      s1_en = 1'b0;
    end else begin
      if (s1_en && !full[s1_lane]) begin
        model_q[s1_lane].push_back(s1_data);
      end
      s1_en   = wr_en;
      s1_lane = wr_lane;
      s1_data = wr_data;
    end
  end

  always @(posedge rd_clk) begin
    if (rst_n && rd_valid) begin
      reads_seen++;
      if (rr_check) begin
        exp_lane = next_busy_lane(last_lane);
        assert (rd_lane == exp_lane) else begin
          $display("FAIL rd_lane expected %h got %h", exp_lane, rd_lane);
          errors++;
        end
      end
      assert (model_q[rd_lane].size() != 0) else begin
        $display("word read from lane %0d while the model holds nothing there", rd_lane);
        errors++;
      end
      if (model_q[rd_lane].size() != 0) begin
        exp_data = model_q[rd_lane].pop_front();
        assert (rd_data == exp_data) else begin
          $display("FAIL rd_data lane %h expected %h got %h", rd_lane, exp_data, rd_data);
          errors++;
        end
      end
      last_lane = rd_lane;
    end
  end

  task automatic write_word(input lane_t lane, input logic [DATA_WIDTH-1:0] data);
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_lane <= lane;
    wr_data <= data;
  endtask

  task automatic write_stop();
    @(posedge wr_clk);
    wr_en <= 1'b0;
  endtask

  task automatic drain();
    @(posedge rd_clk);
    rd_en <= 1'b1;
    while (total_queued() != 0) begin
      @(posedge rd_clk);
    end
    rd_en <= 1'b0;
    repeat (10) @(posedge rd_clk);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    wr_lane     = '0;
    wr_data     = '0;
    rd_en       = 1'b0;
    rr_check    = 1'b0;
    writer_done = 1'b0;
    last_lane   = lane_t'(LANES-1);
    lcg_state   = 32'h75ba;
    errors      = 0;
    reads_seen  = 0;
    repeat (10) @(posedge wr_clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge rd_clk);
    assert (full == '0 && afull == '0) else begin
      $display("FAIL full/afull after reset %h/%h", full, afull);
      errors++;
    end
    assert (empty == '1 && aempty == '1) else begin
      $display("FAIL empty/aempty after reset %h/%h", empty, aempty);
      errors++;
    end
    assert (!rd_valid) else begin
      $display("FAIL rd_valid after reset %h", rd_valid);
      errors++;
    end

    fork
      begin
        for (int c = 0; c < RAND_CYCLES; c++) begin
          @(posedge wr_clk);
          r = next_rand();
          wr_en   <= (r[3:0] < 4'd10);
          wr_lane <= lane_t'(r >> 4);
          wr_data <= DATA_WIDTH'(r >> 8);
        end
        write_stop();
        writer_done = 1'b1;
      end
      begin
        while (!writer_done) begin
          @(posedge rd_clk);
          r = next_rand();
          rd_en <= r[6];
        end
      end
    join
    drain();

    for (int i = 0; i < FIFO_DEPTH+3; i++) begin
      write_word(lane_t'(2), DATA_WIDTH'(i + 8'h40));
    end
    write_stop();
    repeat (10) @(posedge wr_clk);
    assert (full[2] && afull[2]) else begin
      $display("FAIL full/afull of lane 2 %h/%h", full[2], afull[2]);
      errors++;
    end
    assert (model_q[2].size() == FIFO_DEPTH) else begin
      $display("FAIL lane 2 model depth expected %h got %h", FIFO_DEPTH, model_q[2].size());
      errors++;
    end
    reads_before = reads_seen;
    drain();
    assert (reads_seen - reads_before == FIFO_DEPTH) else begin
      $display("FAIL words from lane 2 expected %h got %h", FIFO_DEPTH, reads_seen - reads_before);
      errors++;
    end

    assert (empty == '1 && aempty == '1) else begin
      $display("FAIL empty/aempty after drain %h/%h", empty, aempty);
      errors++;
    end
    reads_before = reads_seen;
    for (int p = 0; p < 5; p++) begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(posedge rd_clk);
      rd_en <= 1'b0;
    end
    repeat (5) @(posedge rd_clk);
    assert (reads_seen == reads_before) else begin
      $display("reads were returned while every lane was empty");
      errors++;
    end

    for (int l = 0; l < LANES; l++) begin
      for (int w = 0; w < RR_WORDS - l; w++) begin
        r = next_rand();
        write_word(lane_t'(l), DATA_WIDTH'(r >> 16));
      end
    end
    write_stop();
    repeat (10) @(posedge rd_clk);
    rr_check = 1'b1;
    drain();
    rr_check = 1'b0;

    $display("errors: %0d, property failures: %0d, words checked: %0d", errors,
             i_cdc_lane_bridge.i_cdc_lane_bridge_properties.fail_count, reads_seen);
    if (errors == 0 && i_cdc_lane_bridge.i_cdc_lane_bridge_properties.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== cdc_lane_bridge.f ====
verilog/fifo_cfg_pkg.sv
verilog/lane_pkg.sv
verilog/dualport_ram.sv
verilog/async_fifo.sv
verilog/lane_dispatch.sv
verilog/lane_merge.sv
verilog/cdc_lane_bridge.sv
bench/cdc_lane_bridge_properties.sv
bench/tb_cdc_lane_bridge.sv

// ==== Makefile ====
BIN  = obj_dir/Vtb_cdc_lane_bridge
SRCS = $(shell grep -v '^+' cdc_lane_bridge.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) cdc_lane_bridge.f
	verilator --binary --timing --assert --top-module tb_cdc_lane_bridge -f cdc_lane_bridge.f

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
